//--- Makefile
# Verilator build and run of the front end testbench

VERILATOR  ?= verilator
TOP        ?= tbFrontEnd
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= SOME TESTS FAILED
PASS_MSG   ?= ALL TESTS PASSED
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dispatchBundle.sv
//########################################
// Output register of the front end
// Captures a four-packet group and its branch count on each fire
// dispatchValid_o is high for one cycle after every fire
//########################################

`timescale 1ns/10ps

module dispatchBundle import frontEndPkg::*; (
  input  logic                              clk,
  input  logic                              rstN_i,
  input  logic                              flush_i,        // Kill pending group
  input  logic                              dispatchFire_i, // Head group leaves
  input  decodedPktT [DISPATCH_WIDTH-1:0]   rdPkts_i,       // Head group
  output decodedPktT [DISPATCH_WIDTH-1:0]   dispatchPkts_o, // Slot 0 oldest
  output logic                              dispatchValid_o,
  output logic [BRANCH_CNT_W-1:0]           branchCount_o
);

  logic [BRANCH_CNT_W-1:0] groupBranches; // Branches in the head group

  always_comb begin
    groupBranches = '0;
    for (int j = 0; j < DISPATCH_WIDTH; j++) begin
      groupBranches = groupBranches + BRANCH_CNT_W'(rdPkts_i[j].isBranch);
    end
  end

  //########################################
  // Group register
  //########################################
  always_ff @(posedge clk) begin
    if (dispatchFire_i) begin
      dispatchPkts_o <= rdPkts_i;      // Payload holds between fires
      branchCount_o  <= groupBranches;
    end
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      dispatchValid_o <= 1'b0;
    end else if (flush_i) begin
      dispatchValid_o <= 1'b0;         // Group at flush edge is dropped
    end else begin
      dispatchValid_o <= dispatchFire_i;
    end
  end

endmodule

//--- frontEndPkg.sv
//########################################
// Shared sizing, opcode and packet types for the front end
// Every front end module wildcard imports this package
// Decoded packets travel as one 72-bit packed struct
//########################################

package frontEndPkg;

  //########################################
  // Sizing
  //########################################
  localparam int INST_QUEUE     = 32;                       // Buffer entries
  localparam int INST_QUEUE_LOG = 5;                        // Pointer width
  localparam int CNT_W          = INST_QUEUE_LOG + 1;       // Occupancy counter width
  localparam int FETCH_WIDTH    = 8;                        // Slots per fetch bundle
  localparam int DISPATCH_WIDTH = 4;                        // Dispatch group size
  localparam int PC_W           = 32;                       // Program counter width
  localparam int INST_W         = 32;                       // Raw instruction word
  localparam int IMM_W          = 20;                       // Decoded immediate width
  localparam int BRANCH_CNT_W   = 3;                        // Holds 0..DISPATCH_WIDTH
  localparam int STALL_LIMIT    = INST_QUEUE - FETCH_WIDTH; // Count above this stalls fetch

  //########################################
  // Opcodes
  //########################################
  // Field codes 10..15 decode to opNop
  typedef enum logic [3:0] {
    opAdd   = 4'd0,
    opSub   = 4'd1,
    opAnd   = 4'd2,
    opOr    = 4'd3,
    opLoad  = 4'd4,
    opStore = 4'd5,
    opBeq   = 4'd6,
    opBne   = 4'd7,
    opJal   = 4'd8,
    opNop   = 4'd9
  } opcodeE;

  //########################################
  // Decoded packet
  //########################################
  // Raw word layout
  //   31:28 opcode, 27:23 rd, 22:18 rs1, 17:13 rs2, 11:0 imm
  typedef struct packed {
    logic [PC_W-1:0]  pc;       // Slot pc, base plus 4*k
    opcodeE           opcode;   // Mapped opcode
    logic [4:0]       rd;       // Destination reg
    logic [4:0]       rs1;      // Source 1
    logic [4:0]       rs2;      // Source 2
    logic [IMM_W-1:0] imm;      // Sign extended from 12 bits
    logic             isBranch; // Beq, bne or jal
  } decodedPktT;

endpackage

//--- frontEndTop.sv
//########################################
// Front end top level
// Decode register, buffer control, buffer storage and dispatch register
// Fetch side offers eight words a cycle, back end takes groups of four
//########################################

`timescale 1ns/10ps

module frontEndTop import frontEndPkg::*; (
  input  logic                                clk,
  input  logic                                rstN_i,
  input  logic [FETCH_WIDTH-1:0][INST_W-1:0] fetchWords_i,
  input  logic [FETCH_WIDTH-1:0]              fetchValid_i,
  input  logic [PC_W-1:0]                     fetchPc_i,
  input  logic                                flush_i,
  input  logic                                dispatchStall_i,
  output logic                                stallFetch_o,
  output logic                                dispatchValid_o,
  output decodedPktT [DISPATCH_WIDTH-1:0]     dispatchPkts_o,
  output logic [BRANCH_CNT_W-1:0]             branchCount_o
);

  decodedPktT [FETCH_WIDTH-1:0]                  decPkts;      // Decode reg payload
  logic [FETCH_WIDTH-1:0]                        decValid;     // Decode reg valid
  logic [FETCH_WIDTH-1:0]                        wrEn;
  logic [FETCH_WIDTH-1:0][INST_QUEUE_LOG-1:0]    wrAddr;
  logic [DISPATCH_WIDTH-1:0][INST_QUEUE_LOG-1:0] rdAddr;
  decodedPktT [DISPATCH_WIDTH-1:0]               rdPkts;       // Head group
  logic                                          dispatchFire;

  instDecoder uDecoder (.clk, .rstN_i, .flush_i, .stallFetch_i(stallFetch_o),
    .fetchWords_i, .fetchValid_i, .fetchPc_i, .decPkts_o(decPkts), .decValid_o(decValid));

  instBufferCtrl uCtrl (.clk, .rstN_i, .flush_i, .dispatchStall_i,
    .decValid_i(decValid), .wrEn_o(wrEn), .wrAddr_o(wrAddr), .rdAddr_o(rdAddr),
    .dispatchFire_o(dispatchFire), .stallFetch_o);

  instBufferRam uRam (.clk, .wrEn_i(wrEn), .wrAddr_i(wrAddr), .wrPkts_i(decPkts),
    .rdAddr_i(rdAddr), .rdPkts_o(rdPkts));

  dispatchBundle uDispatch (.clk, .rstN_i, .flush_i, .dispatchFire_i(dispatchFire),
    .rdPkts_i(rdPkts), .dispatchPkts_o, .dispatchValid_o, .branchCount_o);

endmodule

//--- instBufferCtrl.sv
//########################################
// Pointer and counter control of the instruction buffer
// Compacts valid slots onto the tail, releases groups of four from the head
// Drives write and read addresses of the storage, fetch stall and dispatch fire
//########################################

`timescale 1ns/10ps

module instBufferCtrl import frontEndPkg::*; (
  input  logic                                          clk,
  input  logic                                          rstN_i,
  input  logic                                          flush_i,         // Empty the buffer
  input  logic                                          dispatchStall_i, // Back end busy
  input  logic [FETCH_WIDTH-1:0]                        decValid_i,      // From decode reg
  output logic [FETCH_WIDTH-1:0]                        wrEn_o,          // Per slot write
  output logic [FETCH_WIDTH-1:0][INST_QUEUE_LOG-1:0]    wrAddr_o,        // Compacted addrs
  output logic [DISPATCH_WIDTH-1:0][INST_QUEUE_LOG-1:0] rdAddr_o,        // Head group
  output logic                                          dispatchFire_o,  // Group leaves
  output logic                                          stallFetch_o     // Hold fetch
);

  logic [INST_QUEUE_LOG-1:0] headPtr;   // Oldest entry
  logic [INST_QUEUE_LOG-1:0] tailPtr;   // Next free entry
  logic [CNT_W-1:0]          instCount; // Waiting packets
  logic [CNT_W-1:0]          wrTotal;   // Packets written this edge
  logic [CNT_W-1:0]          nextCount;

  //########################################
  // Fetch stall and dispatch fire
  //########################################
  assign stallFetch_o   = (instCount > CNT_W'(STALL_LIMIT));    // No room for 8 more
  assign dispatchFire_o = (instCount >= CNT_W'(DISPATCH_WIDTH)) && !dispatchStall_i;

  // Held bundle only goes in on an accepted edge
  assign wrEn_o = decValid_i & {FETCH_WIDTH{~stallFetch_o}};

  //########################################
  // Compaction
  //########################################
  // Slot k lands at tail plus the valid slots below it
  always_comb begin : compactAddr
    logic [CNT_W-1:0] offset;
    offset = '0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      wrAddr_o[k] = tailPtr + offset[INST_QUEUE_LOG-1:0]; // Wraps mod 32
      offset      = offset + CNT_W'(wrEn_o[k]);
    end
    wrTotal = offset;
  end

  always_comb begin
    for (int j = 0; j < DISPATCH_WIDTH; j++) begin
      rdAddr_o[j] = headPtr + INST_QUEUE_LOG'(j); // Slot 0 oldest
    end
  end

  assign nextCount = instCount + wrTotal - (dispatchFire_o ? CNT_W'(DISPATCH_WIDTH) : '0);

  //########################################
  // Pointer and count registers
  //########################################
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else if (flush_i) begin
      headPtr   <= '0;           // Whole queue discarded
      tailPtr   <= '0;
      instCount <= '0;
    end else begin
      tailPtr   <= tailPtr + wrTotal[INST_QUEUE_LOG-1:0];
      instCount <= nextCount;
      if (dispatchFire_o) begin
        headPtr <= headPtr + INST_QUEUE_LOG'(DISPATCH_WIDTH);
      end
    end
  end

  //########################################
  // Checks
  //########################################
  // Stall threshold must keep a full bundle from overrunning the queue
  aCountBound: assert property (@(posedge clk) disable iff (!rstN_i)
    instCount <= CNT_W'(INST_QUEUE))
    else $error("instBufferCtrl count overflow %0d", instCount);

  // A stalled edge adds nothing to the queue
  aNoWriteInStall: assert property (@(posedge clk) disable iff (!rstN_i)
    (stallFetch_o && !flush_i) |=>
      ((tailPtr == $past(tailPtr)) && (instCount <= $past(instCount))))
    else $error("instBufferCtrl write while fetch stalled");

  // A group only leaves once four packets sit between head and tail
  aFireNeedsGroup: assert property (@(posedge clk) disable iff (!rstN_i)
    dispatchFire_o |-> (((tailPtr - headPtr) >= INST_QUEUE_LOG'(DISPATCH_WIDTH)) ||
                        (instCount == CNT_W'(INST_QUEUE))))
    else $error("instBufferCtrl fire with count %0d", instCount);

endmodule

//--- instBufferRam.sv
//########################################
// Instruction buffer storage, 32 decoded packets
// Eight write ports on the same edge, four combinational read ports
// Addresses come from the buffer control module
//########################################

`timescale 1ns/10ps

module instBufferRam import frontEndPkg::*; (
  input  logic                                          clk,
  input  logic [FETCH_WIDTH-1:0]                        wrEn_i,   // Per port enable
  input  logic [FETCH_WIDTH-1:0][INST_QUEUE_LOG-1:0]    wrAddr_i, // Per port address
  input  decodedPktT [FETCH_WIDTH-1:0]                  wrPkts_i, // Decoded bundle
  input  logic [DISPATCH_WIDTH-1:0][INST_QUEUE_LOG-1:0] rdAddr_i, // Head group addrs
  output decodedPktT [DISPATCH_WIDTH-1:0]               rdPkts_o  // Head group packets
);

  decodedPktT entries [INST_QUEUE]; // Packet storage
  logic       wrConflict;           // Two enabled ports on one entry

  //########################################
  // Write ports
  //########################################
  always_ff @(posedge clk) begin
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      if (wrEn_i[k]) begin
        entries[wrAddr_i[k]] <= wrPkts_i[k];
      end
    end
  end

  //########################################
  // Read ports
  //########################################
  always_comb begin
    for (int j = 0; j < DISPATCH_WIDTH; j++) begin
      rdPkts_o[j] = entries[rdAddr_i[j]]; // Async read
    end
  end

  // Compacted addresses from the control module must stay distinct
  always_comb begin
    wrConflict = 1'b0;
    for (int a = 0; a < FETCH_WIDTH; a++) begin
      for (int b = a + 1; b < FETCH_WIDTH; b++) begin
        if (wrEn_i[a] && wrEn_i[b] && (wrAddr_i[a] == wrAddr_i[b])) begin
          wrConflict = 1'b1;
        end
      end
    end
  end

  aUniqueWrAddr: assert property (@(posedge clk) !wrConflict)
    else $error("instBufferRam write ports collide");

endmodule

//--- instDecoder.sv
//########################################
// Registered decode stage of the front end
// Turns a fetch bundle of eight raw words into decoded packets
// Loads on every edge with the fetch stall low, holds otherwise
// A flush drops the held valid vector
//########################################

`timescale 1ns/10ps

module instDecoder import frontEndPkg::*; (
  input  logic                                clk,
  input  logic                                rstN_i,
  input  logic                                flush_i,       // Drop held bundle
  input  logic                                stallFetch_i,  // Buffer near full
  input  logic [FETCH_WIDTH-1:0][INST_W-1:0] fetchWords_i,  // Raw words, slot 0 first
  input  logic [FETCH_WIDTH-1:0]              fetchValid_i,  // Slot valid bits
  input  logic [PC_W-1:0]                     fetchPc_i,     // Pc of slot 0
  output decodedPktT [FETCH_WIDTH-1:0]        decPkts_o,     // Held packets
  output logic [FETCH_WIDTH-1:0]              decValid_o     // Held valid vector
);

  decodedPktT [FETCH_WIDTH-1:0] decNext; // Combinational decode of the inputs

  //########################################
  // Field extraction
  //########################################
  function automatic decodedPktT decodeWord(input logic [INST_W-1:0] word,
                                            input logic [PC_W-1:0]   slotPc);
    decodedPktT pkt;
    logic [3:0] opField;
    opField = word[31:28];
    pkt.pc  = slotPc;
    if (opField > 4'd9) begin
      pkt.opcode = opNop;                             // Unused codes
    end else begin
      pkt.opcode = opcodeE'(opField);
    end
    pkt.rd       = word[27:23];
    pkt.rs1      = word[22:18];
    pkt.rs2      = word[17:13];
    pkt.imm      = {{(IMM_W-12){word[11]}}, word[11:0]}; // Sign extend
    pkt.isBranch = (pkt.opcode == opBeq) || (pkt.opcode == opBne) ||
                   (pkt.opcode == opJal);
    return pkt;
  endfunction

  always_comb begin
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      decNext[k] = decodeWord(fetchWords_i[k], fetchPc_i + PC_W'(4 * k)); // 4 bytes per slot
    end
  end

  //########################################
  // Decode register
  //########################################
  // Payload only moves on accepted edges
  always_ff @(posedge clk) begin
    if (!stallFetch_i) begin
      decPkts_o <= decNext;
    end
  end

  // Valid vector is control state
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      decValid_o <= '0;
    end else if (flush_i) begin
      decValid_o <= '0;             // Held and incoming bundles both die
    end else if (!stallFetch_i) begin
      decValid_o <= fetchValid_i;   // Empty bundle simply loads zeros
    end
  end

endmodule

//--- list.f
frontEndPkg.sv
instDecoder.sv
instBufferCtrl.sv
instBufferRam.sv
dispatchBundle.sv
frontEndTop.sv
tbFrontEnd.sv

//--- tbFrontEnd.sv
//########################################
// Testbench for the front end top level
// Random bundles, dispatch stalls and flushes from a fixed seed
// A queue model predicts stall, dispatch valid and every group
//########################################

`timescale 1ns/10ps

module tbFrontEnd import frontEndPkg::*; ();

  localparam int CLK_PERIOD      = 20;   // ns
  localparam int RESET_CYCLES    = 16;
  localparam int TEST_CYCLES     = 3000;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100; // Test length plus margin
  localparam int PHASE_LEN       = 250;  // Cycles per valid density phase

  logic                               clk;
  logic                               rstN;
  logic [FETCH_WIDTH-1:0][INST_W-1:0] fetchWords;
  logic [FETCH_WIDTH-1:0]             fetchValid;
  logic [PC_W-1:0]                    fetchPc;
  logic                               flush;
  logic                               dispatchStall;
  logic                               stallFetch;
  logic                               dispatchValid;
  decodedPktT [DISPATCH_WIDTH-1:0]    dispatchPkts;
  logic [BRANCH_CNT_W-1:0]            branchCount;

  //########################################
  // Model state
  //########################################
  decodedPktT             modelQ[$];                // Buffered packets, oldest first
  decodedPktT             pendPkts [FETCH_WIDTH];   // Decode register copy
  logic [FETCH_WIDTH-1:0] pendValid;
  decodedPktT             expGroup [DISPATCH_WIDTH];
  logic                   expValid;                 // Group expected this cycle
  int                     expBranches;
  int                     errors;
  int                     groups;
  int                     stallCycles;
  int                     flushes;

  frontEndTop dut (
    .clk             (clk),
    .rstN_i          (rstN),
    .fetchWords_i    (fetchWords),
    .fetchValid_i    (fetchValid),
    .fetchPc_i       (fetchPc),
    .flush_i         (flush),
    .dispatchStall_i (dispatchStall),
    .stallFetch_o    (stallFetch),
    .dispatchValid_o (dispatchValid),
    .dispatchPkts_o  (dispatchPkts),
    .branchCount_o   (branchCount)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Expected packet from the raw word layout
  function automatic decodedPktT modelDecode(input logic [INST_W-1:0] word,
                                             input logic [PC_W-1:0]   basePc,
                                             input int                slot);
    decodedPktT p;
    p.pc       = basePc + PC_W'(slot * 4);                // Byte addressed slots
    p.opcode   = (word[31:28] >= 4'd10) ? opNop : opcodeE'(word[31:28]);
    p.rd       = word[27:23];
    p.rs1      = word[22:18];
    p.rs2      = word[17:13];
    p.imm      = IMM_W'($signed(word[11:0]));             // 12 to 20 bits
    p.isBranch = p.opcode inside {opBeq, opBne, opJal};
    return p;
  endfunction

  //########################################
  // Stimulus
  //########################################
  task automatic driveStimulus(input int cyc);
    logic [FETCH_WIDTH-1:0] vec;
    int                     phase;
    phase = (cyc / PHASE_LEN) % 3;
    vec   = FETCH_WIDTH'($urandom);
    if (phase == 1) begin
      vec = vec & FETCH_WIDTH'($urandom) & FETCH_WIDTH'($urandom); // Sparse, queue drains
    end else if (phase == 2) begin
      vec = vec | FETCH_WIDTH'($urandom);                         // Dense, queue fills
    end
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      fetchWords[k] <= $urandom;
    end
    fetchValid    <= vec;
    fetchPc       <= $urandom & ~32'h3;          // Word aligned
    dispatchStall <= (($urandom % 4) == 0);      // About 25 percent
    flush         <= (($urandom % 300) == 0);    // Rare
  endtask

  //########################################
  // Checks and model step
  //########################################
  task automatic checkOutputs();
    logic expStall;
    expStall = (modelQ.size() > INST_QUEUE - FETCH_WIDTH);
    if (stallFetch !== expStall) begin
      errors++;
      $display("mismatch at %0t: stallFetch_o got %b expected %b", $time, stallFetch, expStall);
    end
    if (dispatchValid !== expValid) begin
      errors++;
      $display("mismatch at %0t: dispatchValid_o got %b expected %b",
               $time, dispatchValid, expValid);
    end
    if (expValid && dispatchValid === 1'b1) begin
      groups++;
      for (int j = 0; j < DISPATCH_WIDTH; j++) begin
        if (dispatchPkts[j] !== expGroup[j]) begin
          errors++;
          $display("mismatch at %0t: dispatchPkts_o[%0d] got %h expected %h",
                   $time, j, dispatchPkts[j], expGroup[j]);
        end
      end
      if (branchCount !== BRANCH_CNT_W'(expBranches)) begin
        errors++;
        $display("mismatch at %0t: branchCount_o got %0d expected %0d",
                 $time, branchCount, expBranches);
      end
    end
  endtask

  // Predicts the state after the next rising edge
  task automatic advanceModel();
    logic stallNow;
    logic fireNow;
    stallNow = (modelQ.size() > INST_QUEUE - FETCH_WIDTH);
    fireNow  = (modelQ.size() >= DISPATCH_WIDTH) && !dispatchStall;
    if (flush) begin
      modelQ.delete();                           // Pending and incoming bundles die too
      pendValid = '0;
      expValid  = 1'b0;
      flushes++;
    end else begin
      expValid = fireNow;
      if (fireNow) begin
        expBranches = 0;
        for (int j = 0; j < DISPATCH_WIDTH; j++) begin
          expGroup[j] = modelQ.pop_front();
          if (expGroup[j].isBranch) begin
            expBranches++;
          end
        end
      end
      if (!stallNow) begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
          if (pendValid[k]) begin
            modelQ.push_back(pendPkts[k]);       // Compacted, program order
          end
        end
        for (int k = 0; k < FETCH_WIDTH; k++) begin
          pendPkts[k] = modelDecode(fetchWords[k], fetchPc, k);
        end
        pendValid = fetchValid;
      end else begin
        stallCycles++;                           // Offered bundle ignored
      end
    end
  endtask

  //########################################
  // Main sequence
  //########################################
  initial begin
    void'($urandom(65));
    errors        = 0;
    groups        = 0;
    stallCycles   = 0;
    flushes       = 0;
    pendValid     = '0;
    expValid      = 1'b0;
    expBranches   = 0;
    rstN          = 1'b0;
    fetchWords    = '0;
    fetchValid    = '0;
    fetchPc       = '0;
    flush         = 1'b0;
    dispatchStall = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
      @(posedge clk);
      driveStimulus(cyc);
      @(negedge clk);                            // Outputs settled here
      checkOutputs();
      advanceModel();
    end
    @(posedge clk);
    @(negedge clk);
    checkOutputs();
    if (groups == 0 || stallCycles == 0) begin
      errors++;
      $display("stimulus never produced both dispatch groups and a fetch stall");
    end
    $display("errors %0d, groups %0d, stall cycles %0d, flushes %0d",
             errors, groups, stallCycles, flushes);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #((RESET_CYCLES + WATCHDOG_CYCLES) * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not finish",
             RESET_CYCLES + WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
